// File: source/icache_pkg.sv
package icache_pkg;

    // --------------------------------------------------
    // Cache geometry
    // --------------------------------------------------
    localparam int ADDR_BITS       = 32;
    localparam int OFFSET_BITS     = 3;
    localparam int TAG_BITS        = ADDR_BITS - OFFSET_BITS;
    // Prefetch stride, one block
    localparam int LINE_BYTES      = 8;
    // Must stay a power of two for the PLRU tree
    localparam int ICACHE_LINES    = 8;
    localparam int LINE_INDEX_BITS = $clog2(ICACHE_LINES);

    // Fetch address, seen as a plain word or as tag plus offset
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [OFFSET_BITS-1:0] offset;
        } fields;
    } i_addr_u;

endpackage

// File: source/mem_pkg.sv
package mem_pkg;

    // --------------------------------------------------
    // Memory side
    // --------------------------------------------------
    localparam int BLOCK_BITS      = 64;
    // Tag 0 means no transaction
    localparam int MEM_TAG_BITS    = 4;
    // One spare entry over the 15 usable tags
    localparam int MSHR_DEPTH      = 16;
    localparam int MSHR_INDEX_BITS = $clog2(MSHR_DEPTH);

endpackage

// File: source/snoop_if.sv
`timescale 1ns/1ps

// Prefetch candidate and the two duplicate lookups on it
interface snoop_if;

    logic                cand_valid;
    icache_pkg::i_addr_u cand_addr;
    // Both answers are low while cand_valid is low
    logic                in_cache;
    logic                in_flight;

    modport source  (output cand_valid, output cand_addr);
    modport cache   (input cand_valid, input cand_addr, output in_cache);
    modport queue   (input cand_valid, input cand_addr, output in_flight);
    modport monitor (
        input cand_valid,
        input cand_addr,
        input in_cache,
        input in_flight
    );

endinterface

// File: source/plru_tree.sv
`timescale 1ns/1ps

module plru_tree (
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  logic                                 i_rd0_valid,
    input  logic                                 i_rd1_valid,
    input  logic                                 i_fill_valid,
    input  logic [icache_pkg::LINE_INDEX_BITS-1:0] i_rd0_index,
    input  logic [icache_pkg::LINE_INDEX_BITS-1:0] i_rd1_index,
    input  logic [icache_pkg::LINE_INDEX_BITS-1:0] i_fill_index,
    output logic [icache_pkg::LINE_INDEX_BITS-1:0] o_victim_index
);

    // Heap order, root at 0, children of n at 2n+1 and 2n+2
    // A node bit of 1 points at the right subtree as least recent
    logic [icache_pkg::ICACHE_LINES-2:0] tree_q, tree_d;
    logic [icache_pkg::ICACHE_LINES-2:0] rd0_mask, rd0_val;
    logic [icache_pkg::ICACHE_LINES-2:0] rd1_mask, rd1_val;
    logic [icache_pkg::ICACHE_LINES-2:0] fill_mask, fill_val;

    // Leaf-to-root path of one access and the node values it leaves
    function automatic void path_update(
        input  logic                                 valid,
        input  logic [icache_pkg::LINE_INDEX_BITS-1:0] index,
        output logic [icache_pkg::ICACHE_LINES-2:0]  mask,
        output logic [icache_pkg::ICACHE_LINES-2:0]  val
    );
        int node;
        int parent;
        mask = '0;
        val  = '0;
        node = icache_pkg::ICACHE_LINES - 1 + int'(index);
        if (valid) begin
            for (int lvl = 0; lvl < icache_pkg::LINE_INDEX_BITS; lvl++) begin
                parent = (node - 1) / 2;
                mask[parent] = 1'b1;
                // Odd node is a left child, so the right side becomes older
                val[parent] = node[0];
                node = parent;
            end
        end
    endfunction

    // --------------------------------------------------
    // Per-port paths, merged slot 1 > slot 0 > fill
    // --------------------------------------------------
    always_comb begin
        path_update(i_rd0_valid, i_rd0_index, rd0_mask, rd0_val);
        path_update(i_rd1_valid, i_rd1_index, rd1_mask, rd1_val);
        path_update(i_fill_valid, i_fill_index, fill_mask, fill_val);
        tree_d = (tree_q & ~fill_mask) | (fill_val & fill_mask);
        tree_d = (tree_d & ~rd0_mask) | (rd0_val & rd0_mask);
        tree_d = (tree_d & ~rd1_mask) | (rd1_val & rd1_mask);
    end

    // Victim walk from the root on registered state
    always_comb begin
        int node;
        int leaf;
        node = 0;
        for (int lvl = 0; lvl < icache_pkg::LINE_INDEX_BITS; lvl++) begin
            node = tree_q[node] ? (2 * node + 2) : (2 * node + 1);
        end
        leaf = node - (icache_pkg::ICACHE_LINES - 1);
        o_victim_index = leaf[icache_pkg::LINE_INDEX_BITS-1:0];
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

endmodule

// File: source/icache_array.sv
`timescale 1ns/1ps

module icache_array (
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_rd0_valid,
    input  logic                            i_rd1_valid,
    input  icache_pkg::i_addr_u             i_rd0_addr,
    input  icache_pkg::i_addr_u             i_rd1_addr,
    output logic                            o_hit0,
    output logic                            o_hit1,
    output logic [mem_pkg::BLOCK_BITS-1:0]  o_data0,
    output logic [mem_pkg::BLOCK_BITS-1:0]  o_data1,
    input  logic                            i_fill_valid,
    input  logic [icache_pkg::TAG_BITS-1:0] i_fill_tag,
    input  logic [mem_pkg::BLOCK_BITS-1:0]  i_fill_data,
    output logic                            o_full,
    snoop_if.cache                          snoop
);

    // Line storage, only the valid bits are cleared
    logic [icache_pkg::ICACHE_LINES-1:0] line_valid;
    logic [icache_pkg::TAG_BITS-1:0]     line_tag  [icache_pkg::ICACHE_LINES];
    logic [mem_pkg::BLOCK_BITS-1:0]      line_data [icache_pkg::ICACHE_LINES];

    // Per read slot lookup results
    logic [1:0]                             rd_valid;
    logic [1:0]                             hit;
    logic [icache_pkg::TAG_BITS-1:0]        rd_tag    [2];
    logic [icache_pkg::LINE_INDEX_BITS-1:0] hit_index [2];
    logic [mem_pkg::BLOCK_BITS-1:0]         hit_data  [2];

    logic [icache_pkg::LINE_INDEX_BITS-1:0] free_index;
    logic [icache_pkg::LINE_INDEX_BITS-1:0] victim_index;
    logic [icache_pkg::LINE_INDEX_BITS-1:0] fill_index;

    assign rd_valid  = {i_rd1_valid, i_rd0_valid};
    assign rd_tag[0] = i_rd0_addr.fields.tag;
    assign rd_tag[1] = i_rd1_addr.fields.tag;

    // --------------------------------------------------
    // Dual fully associative read lookup
    // --------------------------------------------------
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            hit[s]       = 1'b0;
            hit_index[s] = '0;
            hit_data[s]  = '0;
            for (int i = 0; i < icache_pkg::ICACHE_LINES; i++) begin
                if (rd_valid[s] && line_valid[i] && (line_tag[i] == rd_tag[s])) begin
                    hit[s]       = 1'b1;
                    hit_index[s] = i[icache_pkg::LINE_INDEX_BITS-1:0];
                    hit_data[s]  = line_data[i];
                end
            end
        end
    end

    assign o_hit0  = hit[0];
    assign o_hit1  = hit[1];
    assign o_data0 = hit_data[0];
    assign o_data1 = hit_data[1];

    // Prefetch candidate already cached
    always_comb begin
        snoop.in_cache = 1'b0;
        for (int i = 0; i < icache_pkg::ICACHE_LINES; i++) begin
            if (snoop.cand_valid && line_valid[i] &&
                (line_tag[i] == snoop.cand_addr.fields.tag)) begin
                snoop.in_cache = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Fill placement
    // --------------------------------------------------
    assign o_full = &line_valid;

    // Descending scan so the lowest invalid line wins
    always_comb begin
        free_index = '0;
        for (int i = icache_pkg::ICACHE_LINES - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                free_index = i[icache_pkg::LINE_INDEX_BITS-1:0];
            end
        end
    end

    assign fill_index = o_full ? victim_index : free_index;

    plru_tree plru (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rd0_valid   (hit[0]),
        .i_rd1_valid   (hit[1]),
        .i_fill_valid  (i_fill_valid),
        .i_rd0_index   (hit_index[0]),
        .i_rd1_index   (hit_index[1]),
        .i_fill_index  (fill_index),
        .o_victim_index(victim_index)
    );

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            line_valid <= '0;
        end else if (i_fill_valid) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_fill_valid) begin
            line_tag[fill_index]  <= i_fill_tag;
            line_data[fill_index] <= i_fill_data;
        end
    end

endmodule

// File: source/miss_queue.sv
`timescale 1ns/1ps

module miss_queue (
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic                               i_push,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0]   i_push_mem_tag,
    input  logic [icache_pkg::TAG_BITS-1:0]    i_push_line_tag,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0]   i_data_tag,
    output logic                               o_fill_valid,
    output logic [icache_pkg::TAG_BITS-1:0]    o_fill_tag,
    snoop_if.queue                             snoop
);

    // Circular FIFO, never fills since depth exceeds the usable tags
    logic [mem_pkg::MSHR_DEPTH-1:0]         q_valid;
    logic [mem_pkg::MEM_TAG_BITS-1:0]       q_mem_tag  [mem_pkg::MSHR_DEPTH];
    logic [icache_pkg::TAG_BITS-1:0]        q_line_tag [mem_pkg::MSHR_DEPTH];
    logic [mem_pkg::MSHR_INDEX_BITS-1:0]    head, tail;
    logic                                   pop;

    // --------------------------------------------------
    // In-order return, only the head can match
    // --------------------------------------------------
    assign pop          = (i_data_tag != '0) && q_valid[head] && (q_mem_tag[head] == i_data_tag);
    assign o_fill_valid = pop;
    assign o_fill_tag   = q_line_tag[head];

    // Candidate already requested and not yet returned
    always_comb begin
        snoop.in_flight = 1'b0;
        for (int i = 0; i < mem_pkg::MSHR_DEPTH; i++) begin
            if (snoop.cand_valid && q_valid[i] &&
                (q_line_tag[i] == snoop.cand_addr.fields.tag)) begin
                snoop.in_flight = 1'b1;
            end
        end
    end

    // Pointers wrap on their own at a power-of-two depth
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            q_valid <= '0;
            head    <= '0;
            tail    <= '0;
        end else begin
            if (pop) begin
                q_valid[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            if (i_push) begin
                q_valid[tail] <= 1'b1;
                tail          <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_push) begin
            q_mem_tag[tail]  <= i_push_mem_tag;
            q_line_tag[tail] <= i_push_line_tag;
        end
    end

endmodule

// File: source/line_prefetcher.sv
`timescale 1ns/1ps

module line_prefetcher (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_miss_valid,
    input  icache_pkg::i_addr_u i_miss_addr,
    input  logic                i_cache_full,
    input  logic                i_accepted,
    snoop_if.source             snoop
);

    // Last accepted demand miss and the running stream pointer
    logic                last_valid;
    icache_pkg::i_addr_u last_miss;
    icache_pkg::i_addr_u stream;
    icache_pkg::i_addr_u next_addr;
    logic                offer_demand;

    // --------------------------------------------------
    // Candidate selection, demand miss first
    // --------------------------------------------------
    always_comb begin
        next_addr.raw = stream.raw + icache_pkg::LINE_BYTES;
        // A full cache stalls the stream, so a repeated miss must get through
        offer_demand = i_miss_valid &&
                       (!last_valid ||
                        (i_miss_addr.fields.tag != last_miss.fields.tag) ||
                        i_cache_full);
        snoop.cand_valid = offer_demand || (!i_cache_full && last_valid);
        snoop.cand_addr  = offer_demand ? i_miss_addr : next_addr;
    end

    // State moves only when memory took the offer
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            last_valid <= 1'b0;
            last_miss  <= '0;
            stream     <= '0;
        end else if (i_accepted) begin
            if (offer_demand) begin
                last_valid <= 1'b1;
                last_miss  <= i_miss_addr;
                // Restart the stream at the new miss
                stream     <= i_miss_addr;
            end else begin
                stream <= next_addr;
            end
        end
    end

endmodule

// File: source/icache_subsystem.sv
`timescale 1ns/1ps

module icache_subsystem (
    input  logic                              i_clock,
    input  logic                              i_reset,
    // Fetch side, slot 0 is the older instruction
    input  logic                              i_read0_valid,
    input  logic                              i_read1_valid,
    input  logic [icache_pkg::ADDR_BITS-1:0]  i_read0_addr,
    input  logic [icache_pkg::ADDR_BITS-1:0]  i_read1_addr,
    output logic                              o_hit0,
    output logic                              o_hit1,
    output logic [mem_pkg::BLOCK_BITS-1:0]    o_data0,
    output logic [mem_pkg::BLOCK_BITS-1:0]    o_data1,
    // Memory side
    input  logic [mem_pkg::MEM_TAG_BITS-1:0]  i_cur_req_tag,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0]  i_mem_data_tag,
    input  logic [mem_pkg::BLOCK_BITS-1:0]    i_mem_data,
    output logic                              o_mem_req_valid,
    output logic [icache_pkg::ADDR_BITS-1:0]  o_mem_req_addr,
    input  logic                              i_mem_req_accepted
);

    snoop_if snoop ();

    icache_pkg::i_addr_u             rd0_addr, rd1_addr, miss_addr, req_addr;
    logic                            miss_valid, cache_full, accepted;
    logic                            fill_valid;
    logic [icache_pkg::TAG_BITS-1:0] fill_tag;

    assign rd0_addr.raw = i_read0_addr;
    assign rd1_addr.raw = i_read1_addr;

    // --------------------------------------------------
    // Oldest miss, slot 0 before slot 1
    // --------------------------------------------------
    always_comb begin
        miss_valid = 1'b1;
        miss_addr  = rd0_addr;
        if (!(i_read0_valid && !o_hit0)) begin
            miss_valid = i_read1_valid && !o_hit1;
            miss_addr  = rd1_addr;
        end
    end

    // Drop candidates already cached or outstanding
    assign o_mem_req_valid = snoop.cand_valid && !snoop.in_cache && !snoop.in_flight;

    // Block aligned request
    always_comb begin
        req_addr              = snoop.cand_addr;
        req_addr.fields.offset = '0;
    end
    assign o_mem_req_addr = req_addr.raw;

    // Tag 0 from memory means nothing was taken
    assign accepted = o_mem_req_valid && i_mem_req_accepted && (i_cur_req_tag != '0);

    icache_array cache (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rd0_valid(i_read0_valid),
        .i_rd1_valid(i_read1_valid),
        .i_rd0_addr (rd0_addr),
        .i_rd1_addr (rd1_addr),
        .o_hit0     (o_hit0),
        .o_hit1     (o_hit1),
        .o_data0    (o_data0),
        .o_data1    (o_data1),
        .i_fill_valid(fill_valid),
        .i_fill_tag (fill_tag),
        .i_fill_data(i_mem_data),
        .o_full     (cache_full),
        .snoop      (snoop)
    );

    miss_queue mshr (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_push         (accepted),
        .i_push_mem_tag (i_cur_req_tag),
        .i_push_line_tag(req_addr.fields.tag),
        .i_data_tag     (i_mem_data_tag),
        .o_fill_valid   (fill_valid),
        .o_fill_tag     (fill_tag),
        .snoop          (snoop)
    );

    line_prefetcher prefetch (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_miss_valid(miss_valid),
        .i_miss_addr (miss_addr),
        .i_cache_full(cache_full),
        .i_accepted  (accepted),
        .snoop       (snoop)
    );

endmodule

// File: verification/icache_assert.sv
`timescale 1ns/1ps

module icache_assert (
    input logic                             i_clock,
    input logic                             i_reset,
    input logic                             i_read0_valid,
    input logic                             i_read1_valid,
    input logic                             i_hit0,
    input logic                             i_hit1,
    input logic                             i_mem_req_valid,
    input logic [icache_pkg::ADDR_BITS-1:0] i_mem_req_addr
);

    // Count of failed assertions
    int fail_count = 0;

    // Requests always name a whole block
    request_aligned: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_mem_req_valid |-> (i_mem_req_addr[icache_pkg::OFFSET_BITS-1:0] == '0)
    ) else begin
        fail_count++;
        $error("request address has a nonzero block offset");
    end

    // A hit needs a read on its own slot
    hit0_needs_read: assert property (
        @(posedge i_clock) disable iff (i_reset) i_hit0 |-> i_read0_valid
    ) else begin
        fail_count++;
        $error("slot 0 hit without a slot 0 read");
    end

    hit1_needs_read: assert property (
        @(posedge i_clock) disable iff (i_reset) i_hit1 |-> i_read1_valid
    ) else begin
        fail_count++;
        $error("slot 1 hit without a slot 1 read");
    end

    // First cycle out of reset stays quiet
    quiet_after_reset: assert property (
        @(posedge i_clock) $fell(i_reset) |-> !i_mem_req_valid
    ) else begin
        fail_count++;
        $error("memory request in the cycle after reset");
    end

endmodule

// File: verification/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int TIMEOUT  = 200;
    // Wait conditions
    localparam int HIT0     = 0;
    localparam int HIT1     = 1;
    localparam int HIT_BOTH = 2;
    localparam int ACCEPTS  = 3;
    localparam int DRAINED  = 4;

    logic        clock = 1'b0;
    logic        reset;
    logic        read0_valid;
    logic        read1_valid;
    logic [31:0] read0_addr;
    logic [31:0] read1_addr;
    logic        hit0;
    logic        hit1;
    logic [63:0] data0;
    logic [63:0] data1;
    logic [3:0]  cur_req_tag;
    logic [3:0]  mem_data_tag;
    logic [63:0] mem_data;
    logic        mem_req_valid;
    logic [31:0] mem_req_addr;
    logic        mem_req_accepted;

    // Memory model state and own records of requests and returns
    integer      seed;
    integer      rnd;
    int          cycle;
    int          fill_count;
    int          mismatch_count;
    int          failure_count;
    logic [3:0]  tag_counter;
    logic [3:0]  pend_tag  [$];
    logic [31:0] pend_addr [$];
    int          pend_due  [$];
    logic [31:0] cached    [$];
    logic [31:0] req_log   [$];

    icache_subsystem UUT (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_read0_valid     (read0_valid),
        .i_read1_valid     (read1_valid),
        .i_read0_addr      (read0_addr),
        .i_read1_addr      (read1_addr),
        .o_hit0            (hit0),
        .o_hit1            (hit1),
        .o_data0           (data0),
        .o_data1           (data1),
        .i_cur_req_tag     (cur_req_tag),
        .i_mem_data_tag    (mem_data_tag),
        .i_mem_data        (mem_data),
        .o_mem_req_valid   (mem_req_valid),
        .o_mem_req_addr    (mem_req_addr),
        .i_mem_req_accepted(mem_req_accepted)
    );

    bind icache_subsystem icache_assert checks (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_read0_valid  (i_read0_valid),
        .i_read1_valid  (i_read1_valid),
        .i_hit0         (o_hit0),
        .i_hit1         (o_hit1),
        .i_mem_req_valid(o_mem_req_valid),
        .i_mem_req_addr (o_mem_req_addr)
    );

    always #20 clock = ~clock;

    // Address in the upper half and its inverse in the lower half
    function automatic logic [63:0] line_data(input logic [31:0] addr);
        return {addr, ~addr};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        mismatch_count++;
        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("%s at %0t", what, $time);
    endtask

    function automatic logic cond_met(input int kind, input int arg);
        case (kind)
            HIT0:     return hit0;
            HIT1:     return hit1;
            HIT_BOTH: return hit0 && hit1;
            ACCEPTS:  return req_log.size() >= arg;
            DRAINED:  return (fill_count >= arg) && (pend_addr.size() == 0);
            default:  return 1'b0;
        endcase
    endfunction

    // Polled on the falling edge, where outputs and records are settled
    task automatic wait_until(input int kind, input int arg, input string what);
        int   n;
        logic done;
        done = 1'b0;
        n    = 0;
        while (!done && n < TIMEOUT) begin
            @(negedge clock);
            done = cond_met(kind, arg);
            n++;
        end
        if (!done) begin
            report_failure({"timeout while waiting for ", what});
        end
    endtask

    // Two reset edges, then one quiet cycle
    task automatic apply_reset();
        reset       = 1'b1;
        read0_valid = 1'b0;
        read1_valid = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
    endtask

    // --------------------------------------------------
    // Memory model
    // --------------------------------------------------
    // Random back-pressure and in-order returns from the head
    always @(negedge clock) begin
        rnd              = $random(seed);
        mem_req_accepted = rnd[0] | rnd[1];
        cur_req_tag      = tag_counter;
        mem_data_tag     = 4'd0;
        mem_data         = 64'd0;
        if (!reset && pend_tag.size() > 0 && pend_due[0] <= cycle) begin
            mem_data_tag = pend_tag[0];
            mem_data     = line_data(pend_addr[0]);
        end
    end

    // Acceptance and return records with duplicate checks
    always @(posedge clock) begin
        cycle = cycle + 1;
        if (reset) begin
            pend_tag.delete();
            pend_addr.delete();
            pend_due.delete();
            cached.delete();
            req_log.delete();
            fill_count = 0;
        end else begin
            if (mem_req_valid && mem_req_accepted) begin
                foreach (pend_addr[i]) begin
                    if (pend_addr[i] == mem_req_addr) begin
                        report_failure("request repeats a line that is still in flight");
                    end
                end
                // Up to 8 fills nothing has been evicted yet
                if (fill_count <= 8) begin
                    foreach (cached[i]) begin
                        if (cached[i] == mem_req_addr) begin
                            report_failure("request repeats a line that is already cached");
                        end
                    end
                end
                pend_tag.push_back(cur_req_tag);
                pend_addr.push_back(mem_req_addr);
                pend_due.push_back(cycle + 3);
                req_log.push_back(mem_req_addr);
                tag_counter = (tag_counter == 4'd15) ? 4'd1 : tag_counter + 4'd1;
            end
            if (mem_data_tag != 4'd0 && pend_tag.size() > 0) begin
                cached.push_back(pend_addr[0]);
                fill_count++;
                void'(pend_tag.pop_front());
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
        end
    end

    // Compare process for every asserted hit
    always @(posedge clock) begin
        if (!reset && hit0 && data0 !== line_data({read0_addr[31:3], 3'b000})) begin
            report_mismatch("o_data0", data0, line_data({read0_addr[31:3], 3'b000}));
        end
        if (!reset && hit1 && data1 !== line_data({read1_addr[31:3], 3'b000})) begin
            report_mismatch("o_data1", data1, line_data({read1_addr[31:3], 3'b000}));
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        integer pick;
        seed           = 32'h28a36ab2;
        reset          = 1'b1;
        read0_valid    = 1'b0;
        read1_valid    = 1'b0;
        read0_addr     = 32'd0;
        read1_addr     = 32'd0;
        cur_req_tag    = 4'd1;
        mem_data_tag   = 4'd0;
        mem_data       = 64'd0;
        mem_req_accepted = 1'b0;
        tag_counter    = 4'd1;
        cycle          = 0;
        fill_count     = 0;
        mismatch_count = 0;
        failure_count  = 0;

        // Reset, cold miss, then hit after the fill
        apply_reset();
        @(posedge clock);
        if (hit0 || hit1 || mem_req_valid) begin
            report_failure("hit or request active right after reset");
        end
        @(negedge clock);
        read0_valid = 1'b1;
        read0_addr  = 32'h0000_1234;
        @(posedge clock);
        if (hit0) begin
            report_failure("cold read hit right after reset");
        end
        if (!mem_req_valid) begin
            report_failure("cold read raised no request");
        end else if (mem_req_addr != 32'h0000_1230) begin
            report_mismatch("o_mem_req_addr", mem_req_addr, 32'h0000_1230);
        end
        wait_until(HIT0, 0, "a hit after the first fill");

        // Single demand miss, then the next-line stream alone
        apply_reset();
        read0_valid = 1'b1;
        read0_addr  = 32'h0000_2000;
        wait_until(ACCEPTS, 1, "the demand request");
        read0_valid = 1'b0;
        wait_until(DRAINED, 8, "eight returned lines");
        if (mem_req_valid) begin
            report_failure("prefetch continued with a full cache");
        end
        for (int i = 0; i < req_log.size(); i++) begin
            if (req_log[i] != 32'h0000_2000 + 32'(i * 8)) begin
                report_mismatch("o_mem_req_addr", req_log[i], 32'h0000_2000 + 32'(i * 8));
            end
        end

        // Both slots miss and slot 0 goes first
        apply_reset();
        read0_valid = 1'b1;
        read1_valid = 1'b1;
        read0_addr  = 32'h0000_4004;
        read1_addr  = 32'h0000_8010;
        @(posedge clock);
        if (!mem_req_valid) begin
            report_failure("dual miss raised no request");
        end else if (mem_req_addr != 32'h0000_4000) begin
            report_mismatch("o_mem_req_addr", mem_req_addr, 32'h0000_4000);
        end
        wait_until(HIT_BOTH, 0, "hits on both slots");

        // Line A held on slot 0 while slot 1 walks 12 new lines
        apply_reset();
        read0_valid = 1'b1;
        read0_addr  = 32'h0001_0000;
        wait_until(HIT0, 0, "a hit on line A");
        for (int i = 0; i < 12; i++) begin
            read1_valid = 1'b1;
            read1_addr  = 32'h0002_0000 + 32'(i * 64);
            wait_until(HIT1, 0, "a hit on a slot 1 line");
            if (!hit0) begin
                report_failure("line A was evicted while read every cycle");
            end
        end

        // Random dual reads over 16 lines
        apply_reset();
        repeat (80) begin
            pick        = $random(seed);
            read0_valid = pick[0];
            read1_valid = pick[1];
            read0_addr  = 32'h0000_3000 | {25'd0, pick[8:2]};
            read1_addr  = 32'h0000_3000 | {25'd0, pick[15:9]};
            @(negedge clock);
        end
        read0_valid = 1'b0;
        read1_valid = 1'b0;
        wait_until(DRAINED, 0, "outstanding requests to return");

        $display("done with %0d mismatches, %0d other failures and %0d assertion failures",
                 mismatch_count, failure_count, UUT.checks.fail_count);
        if (mismatch_count == 0 && failure_count == 0 && UUT.checks.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: list.f
source/icache_pkg.sv
source/mem_pkg.sv
source/snoop_if.sv
source/plru_tree.sv
source/icache_array.sv
source/miss_queue.sv
source/line_prefetcher.sv
source/icache_subsystem.sv
verification/icache_assert.sv
verification/icache_tb.sv
